// File: rtl/lms_frontend_cfg.svh
// Bus widths and counts for the LMS converter front end, included by the package and testbench
`ifndef LMS_FRONTEND_CFG_SVH
`define LMS_FRONTEND_CFG_SVH

// Receive bus from each LMS ADC channel
`define LMS_ADC_WIDTH 12

// Transmit bus to each LMS DAC channel
`define LMS_DAC_WIDTH 12

// Captured sample handed to the DSP side
`define SAMPLE_WIDTH 14

// Transmit word width from the DSP side
`define DAC_WORD_WIDTH 16

// Chip-selects on the shared SPI master
`define SPI_SLAVES 2

`endif

// File: rtl/lms_frontend_pkg.sv
// Shared sample, IQ pair and state types for the LMS front end, imported by every RTL block
`include "lms_frontend_cfg.svh"

package lms_frontend_pkg;

   typedef logic [`LMS_ADC_WIDTH-1:0]  adc_word_t;  // Raw rx bus word
   typedef logic [`SAMPLE_WIDTH-1:0]   sample_t;    // Zero-extended rx sample
   typedef logic [`DAC_WORD_WIDTH-1:0] dac_word_t;  // DSP tx word
   typedef logic [`SPI_SLAVES-1:0]     spi_sel_t;   // One bit per chip-select

   // I in the upper half, Q in the lower half
   typedef struct packed {
      sample_t i;  // In-phase
      sample_t q;  // Quadrature
   } iq_pair_t;

   typedef enum logic {
      WAIT_I = 1'b0,  // No I word held
      HAVE_I = 1'b1   // I word held, waiting for Q
   } rx_state_e;

   typedef enum logic {
      PHASE_I = 1'b0,  // Drive I, iqsel low
      PHASE_Q = 1'b1   // Drive held Q, iqsel high
   } tx_phase_e;

endpackage

// File: rtl/rx_iq_capture.sv
// Splits one interleaved LMS receive bus into I/Q pairs with a one-cycle strobe per pair
module rx_iq_capture
   import lms_frontend_pkg::*;
(
   input  logic      dsp_clk,
   input  logic      reset_i,
   input  logic      rx_en_i,     // Bus word qualifier
   input  logic      rx_iqsel_i,  // Low for I, high for Q
   input  adc_word_t rx_d_i,      // Interleaved I/Q word
   output iq_pair_t  pair_o,      // Completed pair
   output logic      pair_stb_o   // One cycle per completed pair
);

   rx_state_e state_q;  // Pairing FSM
   sample_t   i_hold;   // I word waiting for its Q

   // Control state
   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         state_q    <= WAIT_I;
         pair_stb_o <= 1'b0;
      end
      else
      begin
         pair_stb_o <= 1'b0;  // Default no pair
         if (rx_en_i)
         begin
            if (!rx_iqsel_i)
               state_q <= HAVE_I;  // New I, older one dropped
            else if (state_q == HAVE_I)
            begin
               state_q    <= WAIT_I;  // Pair done
               pair_stb_o <= 1'b1;
            end
            // Q in WAIT_I is an orphan and is ignored
         end
      end
   end

   // Payload path, widened by a cast which zero-fills the top bits
   always_ff @(posedge dsp_clk)
   begin
      if (rx_en_i && !rx_iqsel_i)
         i_hold <= sample_t'(rx_d_i);  // Latest I wins
      if (rx_en_i && rx_iqsel_i && (state_q == HAVE_I))
      begin
         pair_o.i <= i_hold;
         pair_o.q <= sample_t'(rx_d_i);
      end
   end

   // A pair needs an I and a Q, so never two strobes back to back
   a_no_b2b_stb : assert property (
      @(posedge dsp_clk) disable iff (reset_i)
      pair_stb_o |=> !pair_stb_o
   );

endmodule

// File: rtl/rx_pair_align.sv
// Joins the pairs of two receive channels into one aligned sample and flags lost pairs
module rx_pair_align
   import lms_frontend_pkg::*;
(
   input  logic     dsp_clk,
   input  logic     reset_i,
   input  iq_pair_t ch1_pair_i,      // Pair from channel 1 capture
   input  iq_pair_t ch2_pair_i,      // Pair from channel 2 capture
   input  logic     ch1_stb_i,       // Channel 1 pair strobe
   input  logic     ch2_stb_i,       // Channel 2 pair strobe
   output iq_pair_t ch1_sample_o,    // Aligned channel 1 sample
   output iq_pair_t ch2_sample_o,    // Aligned channel 2 sample
   output logic     sample_valid_o,  // One cycle per aligned sample
   output logic     overrun_o        // Sticky, a pair was lost
);

   iq_pair_t ch1_hold;   // Latest channel 1 pair
   iq_pair_t ch2_hold;   // Latest channel 2 pair
   logic     ch1_fresh;  // Channel 1 pair not yet released
   logic     ch2_fresh;  // Channel 2 pair not yet released

   logic     ch1_fresh_nxt;
   logic     ch2_fresh_nxt;
   iq_pair_t ch1_pair_nxt;
   iq_pair_t ch2_pair_nxt;
   logic     release_now;  // Both fresh after this cycle
   logic     lost_pair;    // Strobe onto an unreleased pair

   // This cycle's view including incoming strobes
   assign ch1_fresh_nxt = ch1_fresh | ch1_stb_i;
   assign ch2_fresh_nxt = ch2_fresh | ch2_stb_i;
   assign ch1_pair_nxt  = ch1_stb_i ? ch1_pair_i : ch1_hold;  // Newer pair wins
   assign ch2_pair_nxt  = ch2_stb_i ? ch2_pair_i : ch2_hold;
   assign release_now   = ch1_fresh_nxt & ch2_fresh_nxt;

   // Both fresh never survives an edge, so a fresh channel here is always a pending one
   assign lost_pair = (ch1_stb_i & ch1_fresh) | (ch2_stb_i & ch2_fresh);

   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         ch1_fresh      <= 1'b0;
         ch2_fresh      <= 1'b0;
         sample_valid_o <= 1'b0;
         overrun_o      <= 1'b0;
         ch1_sample_o   <= '0;
         ch2_sample_o   <= '0;
      end
      else
      begin
         sample_valid_o <= release_now;
         if (release_now)
         begin
            ch1_sample_o <= ch1_pair_nxt;  // All four words on one edge
            ch2_sample_o <= ch2_pair_nxt;
            ch1_fresh    <= 1'b0;
            ch2_fresh    <= 1'b0;
         end
         else
         begin
            ch1_fresh <= ch1_fresh_nxt;
            ch2_fresh <= ch2_fresh_nxt;
         end
         if (lost_pair)
            overrun_o <= 1'b1;  // Held until reset
      end
   end

   // Pair storage
   always_ff @(posedge dsp_clk)
   begin
      if (ch1_stb_i)
         ch1_hold <= ch1_pair_i;
      if (ch2_stb_i)
         ch2_hold <= ch2_pair_i;
   end

   // Each channel strobes at most every other cycle, so releases cannot repeat
   a_no_b2b_valid : assert property (
      @(posedge dsp_clk) disable iff (reset_i)
      sample_valid_o |=> !sample_valid_o
   );

endmodule

// File: rtl/tx_iq_interleave.sv
// Interleaves two channels' I/Q words onto the LMS DAC buses, alternating every dsp_clk cycle
`include "lms_frontend_cfg.svh"

module tx_iq_interleave
   import lms_frontend_pkg::*;
(
   input  logic                      dsp_clk,
   input  logic                      reset_i,
   input  dac_word_t                 tx1_i_i,      // Channel 1 I from DSP
   input  dac_word_t                 tx1_q_i,      // Channel 1 Q from DSP
   input  dac_word_t                 tx2_i_i,      // Channel 2 I from DSP
   input  dac_word_t                 tx2_q_i,      // Channel 2 Q from DSP
   output logic [`LMS_DAC_WIDTH-1:0] tx1_d_o,      // Channel 1 DAC bus
   output logic [`LMS_DAC_WIDTH-1:0] tx2_d_o,      // Channel 2 DAC bus
   output logic                      tx1_iqsel_o,  // Low with I, high with Q
   output logic                      tx2_iqsel_o
);

   tx_phase_e                 phase_q;     // Shared by both channels
   logic [`LMS_DAC_WIDTH-1:0] tx1_q_hold;  // Q from the last I edge
   logic [`LMS_DAC_WIDTH-1:0] tx2_q_hold;

   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         phase_q     <= PHASE_I;
         tx1_d_o     <= '0;
         tx2_d_o     <= '0;
         tx1_iqsel_o <= 1'b0;
         tx2_iqsel_o <= 1'b0;
      end
      else if (phase_q == PHASE_I)
      begin
         phase_q     <= PHASE_Q;
         tx1_d_o     <= tx1_i_i[`LMS_DAC_WIDTH-1:0];  // Low bits of I
         tx2_d_o     <= tx2_i_i[`LMS_DAC_WIDTH-1:0];
         tx1_iqsel_o <= 1'b0;
         tx2_iqsel_o <= 1'b0;
      end
      else
      begin
         phase_q     <= PHASE_I;
         tx1_d_o     <= tx1_q_hold;  // Q from the same sampling
         tx2_d_o     <= tx2_q_hold;
         tx1_iqsel_o <= 1'b1;
         tx2_iqsel_o <= 1'b1;
      end
   end

   // Q words are taken with their I words, inputs in PHASE_Q are ignored
   always_ff @(posedge dsp_clk)
   begin
      if (phase_q == PHASE_I)
      begin
         tx1_q_hold <= tx1_q_i[`LMS_DAC_WIDTH-1:0];
         tx2_q_hold <= tx2_q_i[`LMS_DAC_WIDTH-1:0];
      end
   end

   a_iqsel_match : assert property (
      @(posedge dsp_clk) disable iff (reset_i)
      tx1_iqsel_o == tx2_iqsel_o
   );

   // First edge out of reset repeats the low level, toggling starts after it
   a_iqsel_toggle : assert property (
      @(posedge dsp_clk) disable iff (reset_i)
      (!$past(reset_i) && !$past(reset_i, 2)) |-> (tx1_iqsel_o != $past(tx1_iqsel_o))
   );

endmodule

// File: rtl/spi_select_fanout.sv
// Steers the shared SPI master onto each chip-selected device and merges the MISO replies
`include "lms_frontend_cfg.svh"

module spi_select_fanout
   import lms_frontend_pkg::*;
(
   input  logic     dsp_clk,      // Only samples the select check
   input  logic     spi_sclk_i,   // Shared serial clock
   input  logic     spi_mosi_i,   // Shared master data
   input  spi_sel_t spi_sen_n_i,  // Active-low selects
   output spi_sel_t spi_sclk_o,   // Gated clock per slave
   output spi_sel_t spi_mosi_o,   // Gated data per slave
   input  spi_sel_t spi_miso_i,   // Reply per slave
   output logic     spi_miso_o    // Merged reply to master
);

   spi_sel_t sel;  // Active-high select

   assign sel = ~spi_sen_n_i;

   for (genvar s = 0; s < `SPI_SLAVES; s++)
   begin : g_slave
      assign spi_sclk_o[s] = sel[s] & spi_sclk_i;  // Idle low when not selected
      assign spi_mosi_o[s] = sel[s] & spi_mosi_i;
   end

   // Unselected slaves cannot disturb the master
   assign spi_miso_o = |(spi_miso_i & sel);

   // The merge relies on one device talking at a time
   a_one_select : assert property (
      @(posedge dsp_clk)
      $countones(sel) <= 1
   );

endmodule

// File: rtl/lms_frontend.sv
// Top level of the dual-channel LMS converter front end: rx capture and alignment, tx, SPI
`include "lms_frontend_cfg.svh"

module lms_frontend
   import lms_frontend_pkg::*;
(
   input  logic                      dsp_clk,
   input  logic                      reset_i,
   // Receive channel 1
   input  logic                      rx1_en_i,
   input  logic                      rx1_iqsel_i,
   input  adc_word_t                 rx1_d_i,
   // Receive channel 2
   input  logic                      rx2_en_i,
   input  logic                      rx2_iqsel_i,
   input  adc_word_t                 rx2_d_i,
   // Aligned samples to DSP
   output sample_t                   rx1_i_o,
   output sample_t                   rx1_q_o,
   output sample_t                   rx2_i_o,
   output sample_t                   rx2_q_o,
   output logic                      rx_sample_valid_o,
   output logic                      rx_overrun_o,
   // Transmit words from DSP
   input  dac_word_t                 tx1_i_i,
   input  dac_word_t                 tx1_q_i,
   input  dac_word_t                 tx2_i_i,
   input  dac_word_t                 tx2_q_i,
   // DAC buses
   output logic [`LMS_DAC_WIDTH-1:0] tx1_d_o,
   output logic                      tx1_iqsel_o,
   output logic [`LMS_DAC_WIDTH-1:0] tx2_d_o,
   output logic                      tx2_iqsel_o,
   // SPI
   input  logic                      spi_sclk_i,
   input  logic                      spi_mosi_i,
   input  spi_sel_t                  spi_sen_n_i,
   output spi_sel_t                  spi_sclk_o,
   output spi_sel_t                  spi_mosi_o,
   input  spi_sel_t                  spi_miso_i,
   output logic                      spi_miso_o
);

   iq_pair_t ch1_pair;    // Capture to aligner
   iq_pair_t ch2_pair;
   logic     ch1_stb;
   logic     ch2_stb;
   iq_pair_t ch1_sample;  // Aligned output pairs
   iq_pair_t ch2_sample;

   rx_iq_capture u_rx1_capture (
      .dsp_clk    (dsp_clk),
      .reset_i    (reset_i),
      .rx_en_i    (rx1_en_i),
      .rx_iqsel_i (rx1_iqsel_i),
      .rx_d_i     (rx1_d_i),
      .pair_o     (ch1_pair),
      .pair_stb_o (ch1_stb)
   );

   rx_iq_capture u_rx2_capture (
      .dsp_clk    (dsp_clk),
      .reset_i    (reset_i),
      .rx_en_i    (rx2_en_i),
      .rx_iqsel_i (rx2_iqsel_i),
      .rx_d_i     (rx2_d_i),
      .pair_o     (ch2_pair),
      .pair_stb_o (ch2_stb)
   );

   rx_pair_align u_rx_align (
      .dsp_clk        (dsp_clk),
      .reset_i        (reset_i),
      .ch1_pair_i     (ch1_pair),
      .ch2_pair_i     (ch2_pair),
      .ch1_stb_i      (ch1_stb),
      .ch2_stb_i      (ch2_stb),
      .ch1_sample_o   (ch1_sample),
      .ch2_sample_o   (ch2_sample),
      .sample_valid_o (rx_sample_valid_o),
      .overrun_o      (rx_overrun_o)
   );

   assign rx1_i_o = ch1_sample.i;  // Split pairs onto plain ports
   assign rx1_q_o = ch1_sample.q;
   assign rx2_i_o = ch2_sample.i;
   assign rx2_q_o = ch2_sample.q;

   tx_iq_interleave u_tx (
      .dsp_clk     (dsp_clk),
      .reset_i     (reset_i),
      .tx1_i_i     (tx1_i_i),
      .tx1_q_i     (tx1_q_i),
      .tx2_i_i     (tx2_i_i),
      .tx2_q_i     (tx2_q_i),
      .tx1_d_o     (tx1_d_o),
      .tx2_d_o     (tx2_d_o),
      .tx1_iqsel_o (tx1_iqsel_o),
      .tx2_iqsel_o (tx2_iqsel_o)
   );

   spi_select_fanout u_spi (
      .dsp_clk     (dsp_clk),
      .spi_sclk_i  (spi_sclk_i),
      .spi_mosi_i  (spi_mosi_i),
      .spi_sen_n_i (spi_sen_n_i),
      .spi_sclk_o  (spi_sclk_o),
      .spi_mosi_o  (spi_mosi_o),
      .spi_miso_i  (spi_miso_i),
      .spi_miso_o  (spi_miso_o)
   );

endmodule

// File: tests/tb_clock_gen.sv
// Testbench clock and reset source for the LMS front end, instantiated by the testbench top
module tb_clock_gen
(
   output logic clk_o,    // 100 time unit period
   output logic reset_o   // High for the first 5 rising edges
);

   initial
   begin
      clk_o = 1'b0;
      forever #50 clk_o = ~clk_o;
   end

   initial
   begin
      reset_o = 1'b1;
      repeat (5) @(posedge clk_o);
      @(negedge clk_o);
      reset_o = 1'b0;  // Released away from the rising edge
   end

endmodule

// File: tests/tb_lms_frontend.sv
// Testbench for the LMS front end that replays the vector file and checks all outputs every cycle
`include "lms_frontend_cfg.svh"

module tb_lms_frontend
   import lms_frontend_pkg::*;
();

   typedef struct packed {
      logic      rx1_en;
      logic      rx1_iqsel;
      adc_word_t rx1_d;
      logic      rx2_en;
      logic      rx2_iqsel;
      adc_word_t rx2_d;
      dac_word_t tx1_i;
      dac_word_t tx1_q;
      dac_word_t tx2_i;
      dac_word_t tx2_q;
      spi_sel_t  sen_n;
      logic      sclk;
      logic      mosi;
      spi_sel_t  miso;
   } vector_t;

   logic      dsp_clk;
   logic      reset_i;
   vector_t   vectors [$];  // Whole stimulus file
   vector_t   cur;          // Inputs applied this cycle
   int        cycle_count;
   int        cycle_limit;

   sample_t                   rx1_i;
   sample_t                   rx1_q;
   sample_t                   rx2_i;
   sample_t                   rx2_q;
   logic                      rx_valid;
   logic                      rx_overrun;
   logic [`LMS_DAC_WIDTH-1:0] tx1_d;
   logic [`LMS_DAC_WIDTH-1:0] tx2_d;
   logic                      tx1_iqsel;
   logic                      tx2_iqsel;
   spi_sel_t                  spi_sclk;
   spi_sel_t                  spi_mosi;
   logic                      spi_miso;

   // Reference model state with index 0 for channel 1
   rx_state_e                 m_state [2];
   sample_t                   m_ihold [2];
   iq_pair_t                  m_pair [2];
   logic                      m_stb [2];
   iq_pair_t                  m_hold [2];
   logic                      m_fresh [2];
   iq_pair_t                  m_out [2];
   logic                      m_valid;
   logic                      m_overrun;
   tx_phase_e                 m_phase;
   logic [`LMS_DAC_WIDTH-1:0] m_tx_d [2];
   logic [`LMS_DAC_WIDTH-1:0] m_qhold [2];
   logic                      m_iqsel;

   tb_clock_gen u_clock_gen (
      .clk_o   (dsp_clk),
      .reset_o (reset_i)
   );

   lms_frontend uut (
      .dsp_clk           (dsp_clk),
      .reset_i           (reset_i),
      .rx1_en_i          (cur.rx1_en),
      .rx1_iqsel_i       (cur.rx1_iqsel),
      .rx1_d_i           (cur.rx1_d),
      .rx2_en_i          (cur.rx2_en),
      .rx2_iqsel_i       (cur.rx2_iqsel),
      .rx2_d_i           (cur.rx2_d),
      .rx1_i_o           (rx1_i),
      .rx1_q_o           (rx1_q),
      .rx2_i_o           (rx2_i),
      .rx2_q_o           (rx2_q),
      .rx_sample_valid_o (rx_valid),
      .rx_overrun_o      (rx_overrun),
      .tx1_i_i           (cur.tx1_i),
      .tx1_q_i           (cur.tx1_q),
      .tx2_i_i           (cur.tx2_i),
      .tx2_q_i           (cur.tx2_q),
      .tx1_d_o           (tx1_d),
      .tx1_iqsel_o       (tx1_iqsel),
      .tx2_d_o           (tx2_d),
      .tx2_iqsel_o       (tx2_iqsel),
      .spi_sclk_i        (cur.sclk),
      .spi_mosi_i        (cur.mosi),
      .spi_sen_n_i       (cur.sen_n),
      .spi_sclk_o        (spi_sclk),
      .spi_mosi_o        (spi_mosi),
      .spi_miso_i        (cur.miso),
      .spi_miso_o        (spi_miso)
   );

   function automatic vector_t idle_vector();
      vector_t v;
      v       = '0;
      v.sen_n = '1;  // No device selected
      return v;
   endfunction

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected)
      begin
         $display("FAIL at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
         $display("Test FAILED");
         $fatal(1);
      end
   endtask

   task automatic read_vectors();
      int          fd;
      int          count;
      string       line;
      logic [31:0] f [14];
      vector_t     v;
      fd = $fopen("tests/lms_frontend_input.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open the stimulus file tests/lms_frontend_input.txt");
         $display("Test FAILED");
         $fatal(1);
      end
      else
      begin
         while (!$feof(fd))
         begin
            line  = "";
            count = $fgets(line, fd);
            count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                            f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
            if (count == 14)
            begin
               v.rx1_en    = f[0][0];
               v.rx1_iqsel = f[1][0];
               v.rx1_d     = f[2][`LMS_ADC_WIDTH-1:0];
               v.rx2_en    = f[3][0];
               v.rx2_iqsel = f[4][0];
               v.rx2_d     = f[5][`LMS_ADC_WIDTH-1:0];
               v.tx1_i     = f[6][`DAC_WORD_WIDTH-1:0];
               v.tx1_q     = f[7][`DAC_WORD_WIDTH-1:0];
               v.tx2_i     = f[8][`DAC_WORD_WIDTH-1:0];
               v.tx2_q     = f[9][`DAC_WORD_WIDTH-1:0];
               v.sen_n     = f[10][`SPI_SLAVES-1:0];
               v.sclk      = f[11][0];
               v.mosi      = f[12][0];
               v.miso      = f[13][`SPI_SLAVES-1:0];
               vectors.push_back(v);
            end
            else if (count > 0)
            begin
               $display("Stimulus line has the wrong number of columns: %s", line);
               $display("Test FAILED");
               $fatal(1);
            end
         end
         $fclose(fd);
      end
   endtask

   // One rising edge of the reference model
   task automatic model_step();
      logic      en [2];
      logic      iqsel [2];
      adc_word_t d [2];
      logic      fresh_nxt [2];
      iq_pair_t  pair_nxt [2];
      logic      lost;
      en[0]    = cur.rx1_en;
      en[1]    = cur.rx2_en;
      iqsel[0] = cur.rx1_iqsel;
      iqsel[1] = cur.rx2_iqsel;
      d[0]     = cur.rx1_d;
      d[1]     = cur.rx2_d;
      if (reset_i)
      begin
         for (int ch = 0; ch < 2; ch++)
         begin
            m_state[ch] = WAIT_I;
            m_stb[ch]   = 1'b0;
            m_fresh[ch] = 1'b0;
            m_out[ch]   = '0;
            m_tx_d[ch]  = '0;
         end
         m_valid   = 1'b0;
         m_overrun = 1'b0;
         m_phase   = PHASE_I;
         m_iqsel   = 1'b0;
      end
      else
      begin
         // Aligner sees the strobes from the previous edge
         lost = 1'b0;
         for (int ch = 0; ch < 2; ch++)
         begin
            fresh_nxt[ch] = m_fresh[ch] | m_stb[ch];
            pair_nxt[ch]  = m_stb[ch] ? m_pair[ch] : m_hold[ch];  // Newer pair wins
            lost          = lost | (m_stb[ch] & m_fresh[ch]);
            if (m_stb[ch])
               m_hold[ch] = m_pair[ch];
         end
         m_valid = fresh_nxt[0] & fresh_nxt[1];
         for (int ch = 0; ch < 2; ch++)
         begin
            if (m_valid)
            begin
               m_out[ch]   = pair_nxt[ch];
               m_fresh[ch] = 1'b0;
            end
            else
               m_fresh[ch] = fresh_nxt[ch];
         end
         if (lost)
            m_overrun = 1'b1;  // Sticky
         for (int ch = 0; ch < 2; ch++)
         begin
            m_stb[ch] = 1'b0;
            if (en[ch] && !iqsel[ch])
            begin
               m_state[ch] = HAVE_I;
               m_ihold[ch] = d[ch];  // Zero-extended by assignment
            end
            else if (en[ch] && m_state[ch] == HAVE_I)
            begin
               m_state[ch]  = WAIT_I;
               m_stb[ch]    = 1'b1;
               m_pair[ch].i = m_ihold[ch];
               m_pair[ch].q = d[ch];
            end
         end
         if (m_phase == PHASE_I)
         begin
            m_phase    = PHASE_Q;
            m_tx_d[0]  = cur.tx1_i[`LMS_DAC_WIDTH-1:0];
            m_tx_d[1]  = cur.tx2_i[`LMS_DAC_WIDTH-1:0];
            m_qhold[0] = cur.tx1_q[`LMS_DAC_WIDTH-1:0];  // Q taken with its I
            m_qhold[1] = cur.tx2_q[`LMS_DAC_WIDTH-1:0];
            m_iqsel    = 1'b0;
         end
         else
         begin
            m_phase   = PHASE_I;
            m_tx_d[0] = m_qhold[0];
            m_tx_d[1] = m_qhold[1];
            m_iqsel   = 1'b1;
         end
      end
   endtask

   task automatic check_outputs();
      spi_sel_t exp_sclk;
      spi_sel_t exp_mosi;
      logic     exp_miso;
      exp_sclk = '0;  // Unselected slaves idle low
      exp_mosi = '0;
      exp_miso = 1'b0;
      for (int s = 0; s < `SPI_SLAVES; s++)
      begin
         if (!cur.sen_n[s])
         begin
            exp_sclk[s] = cur.sclk;
            exp_mosi[s] = cur.mosi;
            exp_miso    = cur.miso[s];  // Only the selected slave answers
         end
      end
      check_value("rx_sample_valid_o", rx_valid, m_valid);
      check_value("rx_overrun_o", rx_overrun, m_overrun);
      check_value("rx1_i_o", rx1_i, m_out[0].i);
      check_value("rx1_q_o", rx1_q, m_out[0].q);
      check_value("rx2_i_o", rx2_i, m_out[1].i);
      check_value("rx2_q_o", rx2_q, m_out[1].q);
      check_value("tx1_d_o", tx1_d, m_tx_d[0]);
      check_value("tx2_d_o", tx2_d, m_tx_d[1]);
      check_value("tx1_iqsel_o", tx1_iqsel, m_iqsel);
      check_value("tx2_iqsel_o", tx2_iqsel, m_iqsel);
      check_value("spi_sclk_o", spi_sclk, exp_sclk);
      check_value("spi_mosi_o", spi_mosi, exp_mosi);
      check_value("spi_miso_o", spi_miso, exp_miso);
   endtask

   // Run limit from the vector count
   always @(posedge dsp_clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit)
      begin
         $display("Timeout after %0d cycles, the run did not finish", cycle_count);
         $display("Test FAILED");
         $fatal(1);
      end
   end

   initial
   begin
      int idx;
      bit in_reset;
      cur         = idle_vector();
      cycle_count = 0;
      read_vectors();
      cycle_limit = vectors.size() + 20;
      idx         = 0;
      while (idx < vectors.size() + 4)  // Drain cycles after the last vector
      begin
         @(posedge dsp_clk);
         in_reset = reset_i;
         model_step();
         @(negedge dsp_clk);
         check_outputs();  // Outputs settled mid cycle
         if (!in_reset)
         begin
            cur = (idx < vectors.size()) ? vectors[idx] : idle_vector();
            idx++;
         end
      end
      $display("Test OK");
      $finish;
   end

endmodule

// File: tests/lms_frontend_input.txt
# Columns, hex: rx1 en iqsel data, rx2 en iqsel data, tx1_i tx1_q tx2_i tx2_q, sen_n sclk mosi miso
# One line per dsp_clk cycle after reset, lines starting with # are skipped
# Both channels in step
1 0 123 1 0 456 a123 b456 c789 d0ab 3 1 1 3
1 1 abc 1 1 def 1fff 2eee 3ddd 4ccc 2 1 0 1
0 0 000 0 0 000 5bbb 6aaa 7999 8888 2 0 1 2
# Channel 2 lags by three cycles
1 0 111 0 0 000 9777 a666 b555 c444 1 1 1 2
1 1 222 0 0 000 d333 e222 f111 0000 1 0 0 1
0 0 000 1 0 333 0123 4567 89ab cdef 3 1 0 3
0 0 000 0 0 000 fedc ba98 7654 3210 2 1 1 0
0 0 000 1 1 444 1357 2468 9bdf 8ace 1 1 1 3
0 0 000 0 0 000 0f0f f0f0 00ff ff00 2 0 0 3
# Disabled words, orphan Q and a replaced I
0 0 fff 1 1 555 4321 8765 cba9 0fed 1 0 1 1
1 0 aaa 0 0 000 1111 2222 3333 4444 3 0 1 0
1 0 bbb 1 0 666 5555 6666 7777 8888 2 1 1 1
0 1 ccc 1 1 777 9999 aaaa bbbb cccc 1 1 0 2
1 1 ddd 0 0 000 dddd eeee ffff 0001 2 1 0 2
0 0 000 0 0 000 0002 0003 0004 0005 1 0 1 0
# Two channel 1 pairs before any channel 2 pair
1 0 010 0 0 000 c0de f00d beef cafe 3 1 1 1
1 1 020 0 0 000 0bad 1dea 2bed 3fab 2 0 0 0
1 0 030 0 0 000 4ace 5eed 6add 7ebb 1 1 1 1
1 1 040 0 0 000 8f8f 9e9e adad bcbc 2 1 1 2
0 0 000 1 0 050 cbcb dada e9e9 f8f8 1 1 0 0
0 0 000 1 1 060 0707 1616 2525 3434 3 0 0 2
0 0 000 0 0 000 4343 5252 6161 7070 2 0 1 1
# Back to back pairs on both channels
1 0 101 1 0 201 8a8a 9b9b acac bdbd 1 0 1 3
1 1 102 1 1 202 cece dfdf e0e0 f1f1 2 1 0 3
1 0 103 1 0 203 0246 1357 8642 9753 1 1 1 1
1 1 104 1 1 204 a5a5 5a5a c3c3 3c3c 3 1 1 0
0 0 000 0 0 000 ffff 0000 fffe 0001 2 0 1 1

// File: compile.f
+incdir+rtl
rtl/lms_frontend_pkg.sv
rtl/rx_iq_capture.sv
rtl/rx_pair_align.sv
rtl/tx_iq_interleave.sv
rtl/spi_select_fanout.sv
rtl/lms_frontend.sv
tests/tb_clock_gen.sv
tests/tb_lms_frontend.sv
